/* common/mipsPkg.sv */
package mipsPkg;

   // Word-sized values
   typedef logic [31:0] wordT;
   typedef logic [31:0] addrT;
   typedef logic [4:0]  regIdxT;

   // Memory depths in words
   localparam int IMEM_WORDS    = 64;
   localparam int DMEM_WORDS    = 64;
   localparam int IMEM_IDX_BITS = $clog2(IMEM_WORDS);
   localparam int DMEM_IDX_BITS = $clog2(DMEM_WORDS);

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////

   // Opcode field, instr[31:26]
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2B;

   // R-type funct field, instr[5:0]
   localparam logic [5:0] FUNCT_ADDU = 6'h21;
   localparam logic [5:0] FUNCT_SUBU = 6'h23;
   localparam logic [5:0] FUNCT_AND  = 6'h24;
   localparam logic [5:0] FUNCT_OR   = 6'h25;
   localparam logic [5:0] FUNCT_SLT  = 6'h2A;

   // Add is zero so a cleared control word is harmless
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } aluOpT;

   ////////////////////////////////////////
   // Control and pipeline registers
   ////////////////////////////////////////

   typedef struct packed {
      logic  regDst;
      logic  aluSrc;
      logic  memToReg;
      logic  regWrite;
      logic  memRead;
      logic  memWrite;
      logic  branch;
      aluOpT aluOp;
   } ctrlT;

   typedef struct packed {
      addrT pcPlus4;
      wordT instr;
   } ifIdT;

   typedef struct packed {
      ctrlT   ctrl;
      addrT   pcPlus4;
      wordT   readData1;
      wordT   readData2;
      wordT   immExt;
      regIdxT rt;
      regIdxT rd;
   } idExT;

   typedef struct packed {
      ctrlT   ctrl;
      addrT   branchTarget;
      wordT   aluResult;
      logic   zero;
      wordT   storeData;
      regIdxT destReg;
   } exMemT;

   typedef struct packed {
      logic   regWrite;
      logic   memToReg;
      wordT   memData;
      wordT   aluResult;
      regIdxT destReg;
   } memWbT;

endpackage

/* rtl/alu.sv */
`timescale 1ns/100ps

module alu import mipsPkg::*; (
   input  aluOpT aluOp,
   input  wordT  a,
   input  wordT  b,
   output wordT  result,
   output logic  zero
);

   ////////////////////////////////////////
   // Operations
   ////////////////////////////////////////

   always_comb begin
      case (aluOp)
         ALU_ADD: begin
            result = a + b;
         end
         ALU_SUB: begin
            result = a - b;
         end
         ALU_AND: begin
            result = a & b;
         end
         ALU_OR: begin
            result = a | b;
         end
         // Signed compare
         ALU_SLT: begin
            result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         end
         default: begin
            result = '0;
         end
      endcase
   end

   assign zero = (result == '0);

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Op code travels from the decoder through the ID/EX register
   always_comb begin
      aluOpKnown: assert (aluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT})
         else $error("Undefined ALU op %0d", aluOp);
   end

endmodule

/* rtl/controller.sv */
`timescale 1ns/100ps

module controller import mipsPkg::*; (
   input  wordT instr,
   output ctrlT ctrl
);

   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];

   always_comb begin
      ctrl = '0;
      case (opcode)
         OP_RTYPE: begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            case (funct)
               FUNCT_ADDU: ctrl.aluOp = ALU_ADD;
               FUNCT_SUBU: ctrl.aluOp = ALU_SUB;
               FUNCT_AND:  ctrl.aluOp = ALU_AND;
               FUNCT_OR:   ctrl.aluOp = ALU_OR;
               FUNCT_SLT:  ctrl.aluOp = ALU_SLT;
               // sll $0 and friends land here
               default:    ctrl = '0;
            endcase
         end
         OP_ADDIU: begin
            ctrl.aluSrc   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = ALU_ADD;
         end
         OP_LW: begin
            ctrl.aluSrc   = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.aluOp    = ALU_ADD;
         end
         OP_SW: begin
            ctrl.aluSrc   = 1'b1;
            ctrl.memWrite = 1'b1;
            ctrl.aluOp    = ALU_ADD;
         end
         // Compare by subtraction, zero flag decides
         OP_BEQ: begin
            ctrl.branch = 1'b1;
            ctrl.aluOp  = ALU_SUB;
         end
         default: begin
            ctrl = '0;
         end
      endcase
   end

endmodule

/* rtl/dataMemory.sv */
`timescale 1ns/100ps

module dataMemory import mipsPkg::*; (
   input  logic Clk,
   input  addrT addr,
   input  wordT writeData,
   input  logic memWrite,
   input  logic memRead,
   output wordT readData
);

   wordT ram [DMEM_WORDS];
   logic [DMEM_IDX_BITS-1:0] wordIdx;

   // Byte address to word index
   assign wordIdx = addr[DMEM_IDX_BITS+1:2];

   always_ff @(posedge Clk) begin
      if (memWrite) begin
         ram[wordIdx] <= writeData;
      end
   end

   assign readData = memRead ? ram[wordIdx] : '0;

   // Only whole words are supported
   memAligned: assert property (@(posedge Clk) (memRead || memWrite) |-> addr[1:0] == 2'b00)
      else $error("Unaligned data access at %h", addr);

endmodule

/* rtl/instructionMemory.sv */
`timescale 1ns/100ps

module instructionMemory import mipsPkg::*; (
   input  addrT pc,
   output wordT instr
);

   wordT rom [IMEM_WORDS];

   // Unfilled words stay zero, which decodes as a nop
   initial begin
      for (int i = 0; i < IMEM_WORDS; i++) begin
         rom[i] = '0;
      end
      $readmemh("program.hex", rom);
   end

   // Past the end of the ROM
   always_comb begin
      if (pc[31:2] < IMEM_WORDS) begin
         instr = rom[pc[IMEM_IDX_BITS+1:2]];
      end else begin
         instr = '0;
      end
   end

endmodule

/* rtl/mipsTop.sv */
`timescale 1ns/100ps

module mipsTop import mipsPkg::*; (
   input  logic   Clk,
   input  logic   rstN,
   output addrT   debugPc,
   output logic   wbEn,
   output regIdxT wbReg,
   output wordT   wbData
);

   // Pipeline registers
   ifIdT  ifId;
   idExT  idEx;
   exMemT exMem;
   memWbT memWb;

   // Fetch
   addrT pc;
   addrT pcPlus4;
   wordT fetchInstr;
   logic branchTaken;

   // Decode
   ctrlT idCtrl;
   wordT readData1;
   wordT readData2;
   wordT immExt;

   // Execute
   wordT   aluB;
   wordT   aluResult;
   logic   aluZero;
   regIdxT exDestReg;
   addrT   exBranchTarget;

   // Memory and write-back
   wordT memReadData;
   wordT wbWriteData;

   ////////////////////////////////////////
   // Fetch
   ////////////////////////////////////////

   programCounter pc0 (
      .Clk,
      .rstN,
      .branchTaken,
      .branchTarget(exMem.branchTarget),
      .pc
   );

   instructionMemory imem0 (.pc, .instr(fetchInstr));

   assign pcPlus4 = pc + 32'd4;

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         ifId <= '0;
      end else begin
         ifId <= '{pcPlus4: pcPlus4, instr: fetchInstr};
      end
   end

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   controller ctrl0 (.instr(ifId.instr), .ctrl(idCtrl));

   registerFile rf0 (
      .Clk,
      .rstN,
      .rs(ifId.instr[25:21]),
      .rt(ifId.instr[20:16]),
      .writeReg(memWb.destReg),
      .writeData(wbWriteData),
      .writeEn(memWb.regWrite),
      .readData1,
      .readData2
   );

   assign immExt = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         idEx <= '0;
      end else begin
         idEx <= '{ctrl: idCtrl, pcPlus4: ifId.pcPlus4, readData1: readData1,
                   readData2: readData2, immExt: immExt,
                   rt: ifId.instr[20:16], rd: ifId.instr[15:11]};
      end
   end

   ////////////////////////////////////////
   // Execute
   ////////////////////////////////////////

   assign aluB           = idEx.ctrl.aluSrc ? idEx.immExt : idEx.readData2;
   assign exDestReg      = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
   // Word offset relative to the delay slot address
   assign exBranchTarget = idEx.pcPlus4 + {idEx.immExt[29:0], 2'b00};

   alu alu0 (
      .aluOp(idEx.ctrl.aluOp),
      .a(idEx.readData1),
      .b(aluB),
      .result(aluResult),
      .zero(aluZero)
   );

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         exMem <= '0;
      end else begin
         exMem <= '{ctrl: idEx.ctrl, branchTarget: exBranchTarget, aluResult: aluResult,
                    zero: aluZero, storeData: idEx.readData2, destReg: exDestReg};
      end
   end

   ////////////////////////////////////////
   // Memory
   ////////////////////////////////////////

   dataMemory dmem0 (
      .Clk,
      .addr(exMem.aluResult),
      .writeData(exMem.storeData),
      .memWrite(exMem.ctrl.memWrite),
      .memRead(exMem.ctrl.memRead),
      .readData(memReadData)
   );

   // beq resolves here, three slots behind fetch
   assign branchTaken = exMem.ctrl.branch & exMem.zero;

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         memWb <= '0;
      end else begin
         memWb <= '{regWrite: exMem.ctrl.regWrite, memToReg: exMem.ctrl.memToReg,
                    memData: memReadData, aluResult: exMem.aluResult,
                    destReg: exMem.destReg};
      end
   end

   ////////////////////////////////////////
   // Write-back
   ////////////////////////////////////////

   assign wbWriteData = memWb.memToReg ? memWb.memData : memWb.aluResult;

   assign debugPc = pc;
   assign wbEn    = memWb.regWrite && (memWb.destReg != '0);
   assign wbReg   = memWb.destReg;
   assign wbData  = wbWriteData;

endmodule

/* rtl/programCounter.sv */
`timescale 1ns/100ps

module programCounter import mipsPkg::*; (
   input  logic Clk,
   input  logic rstN,
   input  logic branchTaken,
   input  addrT branchTarget,
   output addrT pc
);

   addrT pcNext;

   // Branch from the memory stage wins over sequential fetch
   always_comb begin
      if (branchTaken) begin
         pcNext = branchTarget;
      end else begin
         pcNext = pc + 32'd4;
      end
   end

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else begin
         pc <= pcNext;
      end
   end

   // Target comes from the EX-stage adder, several modules away
   pcAligned: assert property (@(posedge Clk) disable iff (!rstN) pc[1:0] == 2'b00)
      else $error("PC not word aligned: %h", pc);

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/100ps

module registerFile import mipsPkg::*; (
   input  logic   Clk,
   input  logic   rstN,
   input  regIdxT rs,
   input  regIdxT rt,
   input  regIdxT writeReg,
   input  wordT   writeData,
   input  logic   writeEn,
   output wordT   readData1,
   output wordT   readData2
);

   wordT regs [32];

   // One read port; a write in flight is seen in the same cycle
   function automatic wordT readPort(regIdxT idx);
      if (idx == '0) begin
         return '0;
      end else if (writeEn && writeReg == idx) begin
         return writeData;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && writeReg != '0) begin
         regs[writeReg] <= writeData;
      end
   end

   always_comb begin
      readData1 = readPort(rs);
      readData2 = readPort(rt);
   end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the MIPS pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

# The instruction ROM loads program.hex from the working directory
cp sim/program.hex program.hex

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
   --top-module tbMips -f vlog.f -o simMips

# A failing run exits non-zero, the log decides the result
./obj_dir/simMips > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

/* sim/program.hex */
// One 32-bit instruction word per line in hex, from address 0
// Text after each word is the assembly of that word
24010005 // addiu $1, $0, 5
2402FFFD // addiu $2, $0, -3
24037F00 // addiu $3, $0, 0x7f00
24000007 // addiu $0, $0, 7      no write-back
00222021 // addu  $4, $1, $2
00412823 // subu  $5, $2, $1
0041302A // slt   $6, $2, $1     negative compare
0022382A // slt   $7, $1, $2
00624024 // and   $8, $3, $2
00614825 // or    $9, $3, $1
00055021 // addu  $10, $0, $5    reads $0
AC050010 // sw    $5, 16($0)
AC090014 // sw    $9, 20($0)
8C0C0010 // lw    $12, 16($0)
8C0D0014 // lw    $13, 20($0)
240E0001 // addiu $14, $0, 1
240F0001 // addiu $15, $0, 1
24100002 // addiu $16, $0, 2
24110009 // addiu $17, $0, 9
11CF0005 // beq   $14, $15, +5   taken
24120021 // addiu $18, $0, 0x21 delay slot
24130022 // addiu $19, $0, 0x22 delay slot
24140023 // addiu $20, $0, 0x23 delay slot
24150066 // addiu $21, $0, 0x66 skipped
24160077 // addiu $22, $0, 0x77 skipped
24170044 // addiu $23, $0, 0x44 branch target
11D00001 // beq   $14, $16, +1   not taken
24180055 // addiu $24, $0, 0x55
24190056 // addiu $25, $0, 0x56
008CD021 // addu  $26, $4, $12
018DD82A // slt   $27, $12, $13
00220025 // or    $0, $1, $2     no write-back

/* sim/tbMips.sv */
`timescale 1ns/100ps

module tbMips import mipsPkg::*; ();

   logic   Clk;
   logic   rstN;
   addrT   debugPc;
   logic   wbEn;
   regIdxT wbReg;
   wordT   wbData;

   // Program image and expected write-back trace
   wordT   progWords [IMEM_WORDS];
   regIdxT expReg [$];
   wordT   expData [$];
   int     expCycle [$];

   mipsTop dut0 (
      .Clk,
      .rstN,
      .debugPc,
      .wbEn,
      .wbReg,
      .wbData
   );

   ////////////////////////////////////////
   // Clock and reset
   ////////////////////////////////////////

   initial begin
      Clk = 1'b0;
   end

   always #50 Clk = ~Clk;

   initial begin
      rstN = 1'b0;
      runModel();
      repeat (2) begin
         @(posedge Clk);
      end
      rstN <= 1'b1;
   end

   ////////////////////////////////////////
   // ISA reference model
   ////////////////////////////////////////

   // Runs the program in order; step number equals the fetch cycle
   function automatic void runModel();
      wordT   regs [32];
      wordT   dmemWords [DMEM_WORDS];
      wordT   instr;
      wordT   imm;
      wordT   result;
      addrT   pc;
      addrT   nextPc;
      addrT   target;
      addrT   effAddr;
      regIdxT rs;
      regIdxT rt;
      regIdxT dest;
      logic   writes;
      logic   taken;
      int     slotsLeft;
      int     step;

      for (int i = 0; i < IMEM_WORDS; i++) begin
         progWords[i] = '0;
      end
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmemWords[i] = '0;
      end
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      $readmemh("sim/program.hex", progWords);

      pc        = '0;
      target    = '0;
      slotsLeft = 0;
      step      = 0;
      while (step < 16 * IMEM_WORDS) begin
         if ((pc >> 2) < IMEM_WORDS) begin
            instr = progWords[pc[IMEM_IDX_BITS+1:2]];
         end else begin
            instr = '0;
         end
         // First empty word ends the program
         if (instr == '0) begin
            break;
         end

         rs      = instr[25:21];
         rt      = instr[20:16];
         imm     = {{16{instr[15]}}, instr[15:0]};
         dest    = rt;
         result  = '0;
         writes  = 1'b0;
         taken   = 1'b0;
         effAddr = regs[rs] + imm;

         case (instr[31:26])
            OP_RTYPE: begin
               dest   = instr[15:11];
               writes = 1'b1;
               case (instr[5:0])
                  FUNCT_ADDU: result = regs[rs] + regs[rt];
                  FUNCT_SUBU: result = regs[rs] - regs[rt];
                  FUNCT_AND:  result = regs[rs] & regs[rt];
                  FUNCT_OR:   result = regs[rs] | regs[rt];
                  FUNCT_SLT:  result = {31'd0, $signed(regs[rs]) < $signed(regs[rt])};
                  default:    writes = 1'b0;
               endcase
            end
            OP_ADDIU: begin
               writes = 1'b1;
               result = regs[rs] + imm;
            end
            OP_LW: begin
               writes = 1'b1;
               result = dmemWords[effAddr[DMEM_IDX_BITS+1:2]];
            end
            OP_SW: begin
               dmemWords[effAddr[DMEM_IDX_BITS+1:2]] = regs[rt];
            end
            OP_BEQ: begin
               taken = (regs[rs] == regs[rt]);
            end
            default: begin
               writes = 1'b0;
            end
         endcase

         // $0 is never written and gives no pulse
         if (writes && dest != '0) begin
            regs[dest] = result;
            expReg.push_back(dest);
            expData.push_back(result);
            expCycle.push_back(step + 4);
         end

         // Three delay slots run before the redirect
         nextPc = pc + 32'd4;
         if (slotsLeft > 0) begin
            slotsLeft--;
            if (slotsLeft == 0) begin
               nextPc = target;
            end
         end
         if (taken) begin
            slotsLeft = 3;
            target    = pc + 32'd4 + (imm << 2);
         end
         pc = nextPc;
         step++;
      end
   endfunction

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic abortRun();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic checkReg(input string name, input regIdxT actual, input regIdxT expected);
      if (actual !== expected) begin
         $display("Fail %s: got %h, expected %h", name, actual, expected);
         abortRun();
      end
   endtask

   task automatic checkWord(input string name, input wordT actual, input wordT expected);
      if (actual !== expected) begin
         $display("Fail %s: got %h, expected %h", name, actual, expected);
         abortRun();
      end
   endtask

   task automatic checkAddr(input string name, input addrT actual, input addrT expected);
      if (actual !== expected) begin
         $display("Fail %s: got %h, expected %h", name, actual, expected);
         abortRun();
      end
   endtask

   task automatic checkCycle(input string name, input int actual, input int expected);
      if (actual !== expected) begin
         $display("Fail %s: got %h, expected %h", name, actual, expected);
         abortRun();
      end
   endtask

   ////////////////////////////////////////
   // Write-back monitor
   ////////////////////////////////////////

   // Outputs sampled on the falling edge, cycle 0 fetches address 0
   initial begin : compareWrites
      int cycle;
      int waited;

      waited = 0;
      while (rstN !== 1'b1) begin
         if (waited > 8) begin
            $display("Reset was never released");
            abortRun();
         end
         @(negedge Clk);
         waited++;
      end

      if (expReg.size() == 0) begin
         $display("Reference model found no register writes in sim/program.hex");
         abortRun();
      end
      checkAddr("debugPc", debugPc, 32'h0);

      cycle = 0;
      for (int idx = 0; idx < expReg.size(); idx++) begin
         // Longer than the whole ROM means the pipeline is stuck
         waited = 0;
         while (wbEn !== 1'b1) begin
            if (waited > IMEM_WORDS) begin
               $display("Timed out: write %0d to register %0d never came",
                        idx, expReg[idx]);
               abortRun();
            end
            @(negedge Clk);
            cycle++;
            waited++;
         end
         checkCycle("wbEn cycle", cycle, expCycle[idx]);
         checkReg("wbReg", wbReg, expReg[idx]);
         checkWord("wbData", wbData, expData[idx]);
         @(negedge Clk);
         cycle++;
      end

      // Trailing writes to $0 must stay silent
      repeat (5) begin
         if (wbEn !== 1'b0) begin
            $display("Unexpected write to register %0d after the last expected write",
                     wbReg);
            abortRun();
         end
         @(negedge Clk);
      end

      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* vlog.f */
common/mipsPkg.sv
rtl/programCounter.sv
rtl/instructionMemory.sv
rtl/registerFile.sv
rtl/controller.sv
rtl/alu.sv
rtl/dataMemory.sv
rtl/mipsTop.sv
sim/tbMips.sv
